// File: project.f
+incdir+dv
common/sd_dispatch_pkg.sv
hdl/sd_req_sync.sv
hdl/sd_grant_arbiter.sv
hdl/sd_card_port.sv
hdl/sd_dispatch_top.sv
dv/sd_dispatch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the SD dispatcher testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps \
   -f project.f \
   --top-module sd_dispatch_tb

./obj_dir/Vsd_dispatch_tb | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// File: dv/sd_dispatch_tests.svh
`ifndef SD_DISPATCH_TESTS_SVH
`define SD_DISPATCH_TESTS_SVH

//******************************
//* handshake steps
//******************************
// grant shows up on the third falling edge after the request
task automatic raise_and_check(input ctrl_vec_t reqs, input ctrl_e winner);
   sd_req = sd_req | reqs;
   for (int c = 1; c <= 3; c++) begin
      tick();
      check_outputs((c == 3) ? ctrl_bit(winner) : '0,
                    $sformatf("%s request, cycle %0d", winner.name(), c));
   end
endtask

// grant falls on the third edge, next owner one idle cycle later
task automatic release_and_check(input ctrl_e owner, input ctrl_vec_t next_grant);
   ctrl_vec_t exp;
   sd_req[owner] = 1'b0;                          // owner done with the card
   for (int c = 1; c <= 4; c++) begin
      tick();
      exp = (c < 3) ? ctrl_bit(owner) : ((c == 3) ? '0 : next_grant);
      check_outputs(exp, $sformatf("%s release, cycle %0d", owner.name(), c));
   end
endtask

//******************************
//* directed tests
//******************************
task automatic test_reset_state();
   int errs;
   errs = err_cnt;
   reset_dut();
   check_outputs('0, "right after reset");
   repeat (3) begin
      tick();
      check_outputs('0, "idle after reset");     // nobody requested
   end
   finish_test("reset_state", errs);
endtask

task automatic test_single_owner();
   int          errs;
   logic [31:0] r;
   ctrl_e       c;
   errs = err_cnt;
   for (int i = 0; i < n_ctrl; i++) begin
      c = ctrl_e'(i);
      raise_and_check(ctrl_bit(c), c);
      repeat (6) begin
         r = next_rand();
         ctrl_spi[c] = sd_spi_t'(r[2:0]);        // owner toggles its lines
         tick();
         check_outputs(ctrl_bit(c), $sformatf("%s lines moving", c.name()));
      end
      release_and_check(c, '0);
      set_spi_patterns();
   end
   finish_test("single_owner", errs);
endtask

task automatic test_priority();
   int errs;
   errs = err_cnt;
   raise_and_check('1, CTRL_RK);                  // all six at once
   for (int i = 0; i < n_ctrl; i++) begin
      release_and_check(ctrl_e'(i), (i < n_ctrl - 1) ? ctrl_bit(ctrl_e'(i + 1)) : '0);
   end
   finish_test("priority", errs);
endtask

task automatic test_no_preempt();
   int errs;
   errs = err_cnt;
   raise_and_check(ctrl_bit(CTRL_MY), CTRL_MY);
   sd_req[CTRL_RK] = 1'b1;                        // higher priority arrives late
   repeat (8) begin
      tick();
      check_outputs(ctrl_bit(CTRL_MY), "MY keeps the card while RK waits");
   end
   release_and_check(CTRL_MY, ctrl_bit(CTRL_RK));
   release_and_check(CTRL_RK, '0);
   finish_test("no_preempt", errs);
endtask

// controller model: 0 quiet, 1 requesting, 2 dropped and waiting for grant low
task automatic test_random_sharing();
   int          errs;
   int          grants;
   int          st [n_ctrl];
   logic [31:0] r;
   logic [31:0] s;
   ctrl_e       ci;
   errs   = err_cnt;
   grants = 0;
   for (int i = 0; i < n_ctrl; i++) begin
      st[i] = 0;
   end
   for (int cyc = 0; cyc < 360; cyc++) begin
      tick();
      check_eq(32'($countones(sd_grant) > 1), 32'd0, "more than one grant high");
      check_eq(32'(card_spi), 32'(expected_card(sd_grant)), "card lines differ from owner");
      check_eq(32'(disk_led_n), 32'(ctrl_vec_t'(~sd_req)), "leds differ from requests");
      r = next_rand();
      for (int i = 0; i < n_ctrl; i++) begin
         ci = ctrl_e'(i);
         if (sd_grant[i]) begin
            check_eq(32'(st[i] != 0), 32'd1, $sformatf("%s granted unasked", ci.name()));
         end
         case (st[i])
            0: if (cyc < 300 && r[4*i +: 2] == 2'd0) begin
               sd_req[i] = 1'b1;                  // new request
               st[i]     = 1;
            end
            1: if (sd_grant[i] && (cyc >= 300 || r[4*i+2 +: 2] == 2'd0)) begin
               sd_req[i] = 1'b0;                  // done with the card
               st[i]     = 2;
               grants++;
            end
            default: if (!sd_grant[i]) begin
               st[i] = 0;                         // saw its grant fall
            end
         endcase
      end
      s = next_rand();
      ctrl_spi = sd_spi_vec_t'(s[17:0]);          // fresh lines every cycle
   end
   check_eq(32'(sd_req | sd_grant), 32'd0, "requests or grants left after random run");
   check_eq(32'(grants > 10), 32'd1, "too few grants in random run");
   set_spi_patterns();
   finish_test("random_sharing", errs);
endtask

task automatic test_reset_busy();
   int errs;
   errs = err_cnt;
   raise_and_check(ctrl_bit(CTRL_DX), CTRL_DX);
   tick();
   check_outputs(ctrl_bit(CTRL_DX), "DX holds the card");
   arst_n_i = 1'b0;                               // mid ownership
   #10;                                           // well before the next rising edge
   check_outputs('0, "reset clears grant without a clock edge");
   repeat (2) begin
      tick();
      check_outputs('0, "held in reset");
   end
   arst_n_i = 1'b1;                               // DX still requesting
   raise_and_check(ctrl_bit(CTRL_DX), CTRL_DX);
   release_and_check(CTRL_DX, '0);
   raise_and_check(ctrl_bit(CTRL_DW), CTRL_DW);   // normal arbitration again
   release_and_check(CTRL_DW, '0);
   finish_test("reset_busy", errs);
endtask

`endif

// File: dv/sd_dispatch_tb.sv
`timescale 1ns/100ps

module sd_dispatch_tb
   import sd_dispatch_pkg::*;
();

   //******************************
   //* run length
   //******************************
   // cycles per test: reset, single, priority, no preempt, random, reset busy
   localparam int test_cycles = 10 + 90 + 35 + 20 + 370 + 25;
   localparam int watchdog_ns = test_cycles * 2 * 100;         // twice the tests, 100 ns period

   logic        sdclock = 1'b0;                   // sd card clock
   logic        arst_n_i;                         // async reset, active low
   ctrl_vec_t   sd_req;                           // controller requests
   sd_spi_vec_t ctrl_spi;                         // controller card lines
   ctrl_vec_t   sd_grant;
   sd_spi_t     card_spi;
   ctrl_vec_t   disk_led_n;

   int          chk_cnt   = 0;                    // checks done
   int          err_cnt   = 0;                    // checks failed
   logic [31:0] rng_state = 32'h17bf7b1f;         // xorshift seed

   sd_dispatch_top UUT (
      .sdclock      (sdclock),
      .arst_n_i     (arst_n_i),
      .sd_req_i     (sd_req),
      .ctrl_spi_i   (ctrl_spi),
      .sd_grant_o   (sd_grant),
      .card_spi_o   (card_spi),
      .disk_led_n_o (disk_led_n)
   );

   always #50 sdclock = ~sdclock;                 // 100 ns period

   //******************************
   //* helpers
   //******************************
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;                              // advance the generator
      return x;
   endfunction

   task automatic tick();
      @(negedge sdclock);                         // inputs move here, outputs are stable
   endtask

   function automatic ctrl_vec_t ctrl_bit(input ctrl_e c);
      return ctrl_vec_t'(1) << c;                 // one bit per controller
   endfunction

   // card lines the dispatcher should drive for a given grant
   function automatic sd_spi_t expected_card(input ctrl_vec_t g);
      sd_spi_t e;
      e.cs   = idle_cs;                           // nobody owns the card
      e.mosi = idle_mosi;
      e.sclk = idle_sclk;
      for (int i = 0; i < n_ctrl; i++) begin
         if (g[i]) begin
            e = ctrl_spi[i];                      // owner lines pass through
         end
      end
      return e;
   endfunction

   // distinct lines per controller, none equal to the idle levels
   task automatic set_spi_patterns();
      for (int i = 0; i < n_ctrl; i++) begin
         ctrl_spi[i] = (i < 5) ? sd_spi_t'(3'(i + 1)) : sd_spi_t'(3'd7);
      end
   endtask

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      end
   endtask

   task automatic check_outputs(input ctrl_vec_t exp_grant, input string tag);
      check_eq(32'(sd_grant), 32'(exp_grant), {tag, ": grant"});
      check_eq(32'(card_spi), 32'(expected_card(exp_grant)), {tag, ": card lines"});
      check_eq(32'(disk_led_n), 32'(ctrl_vec_t'(~sd_req)), {tag, ": leds"});   // lit while requesting
   endtask

   task automatic finish_test(input string name, input int errs_before);
      $display("test %-16s done, %0d errors", name, err_cnt - errs_before);
   endtask

   task automatic reset_dut();
      arst_n_i = 1'b0;
      sd_req   = '0;
      repeat (5) tick();                          // reset held 5 cycles
      arst_n_i = 1'b1;
   endtask

   `include "sd_dispatch_tests.svh"

   //******************************
   //* watchdog
   //******************************
   initial begin
      #(watchdog_ns);
      $display("run timed out after %0d ns, the tests did not finish", watchdog_ns);
      $display("TESTBENCH FAILED");
      $finish;
   end

   //******************************
   //* test sequence
   //******************************
   initial begin
      arst_n_i = 1'b0;                            // all inputs known from time 0
      sd_req   = '0;
      set_spi_patterns();
      test_reset_state();
      test_single_owner();
      test_priority();
      test_no_preempt();
      test_random_sharing();
      test_reset_busy();
      $display("checks run %0d, passed %0d, failed %0d", chk_cnt, chk_cnt - err_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: hdl/sd_dispatch_top.sv
`timescale 1ns/100ps

// sd card dispatcher for the RK, DW, DM, DB, DX and MY controllers
module sd_dispatch_top
   import sd_dispatch_pkg::*;
(
   input  logic        sdclock,                   // sd card clock
   input  logic        arst_n_i,                  // async reset, active low
   input  ctrl_vec_t   sd_req_i,                  // card requests from the controllers
   input  sd_spi_vec_t ctrl_spi_i,                // spi lines of the controllers
   output ctrl_vec_t   sd_grant_o,                // card grants to the controllers
   output sd_spi_t     card_spi_o,                // spi lines to the card
   output ctrl_vec_t   disk_led_n_o               // disk activity leds
);

   ctrl_vec_t req_sync;                           // requests in sdclock domain
   ctrl_vec_t grant;                              // current owner, one-hot

   //******************************
   //* request filter
   //******************************
   sd_req_sync u_req_sync (
      .sdclock    (sdclock),
      .arst_n_i   (arst_n_i),
      .req_i      (sd_req_i),                     // straight from the bus domains
      .req_sync_o (req_sync)
   );

   //******************************
   //* grant arbiter
   //******************************
   sd_grant_arbiter u_grant_arbiter (
      .sdclock    (sdclock),
      .arst_n_i   (arst_n_i),
      .req_sync_i (req_sync),
      .grant_o    (grant)
   );

   //******************************
   //* card port
   //******************************
   sd_card_port u_card_port (
      .grant_i      (grant),
      .ctrl_spi_i   (ctrl_spi_i),
      .req_i        (sd_req_i),                   // leds use the raw level
      .card_spi_o   (card_spi_o),
      .disk_led_n_o (disk_led_n_o)
   );

   assign sd_grant_o = grant;                     // back to the controllers

endmodule

// File: hdl/sd_card_port.sv
`timescale 1ns/100ps

// switches the spi lines of the owning controller onto the card
// purely combinational, follows grant in the same cycle
module sd_card_port
   import sd_dispatch_pkg::*;
(
   input  ctrl_vec_t   grant_i,                   // one-hot grant from the arbiter
   input  sd_spi_vec_t ctrl_spi_i,                // card lines of every controller
   input  ctrl_vec_t   req_i,                     // raw requests for the leds
   output sd_spi_t     card_spi_o,                // lines toward the card
   output ctrl_vec_t   disk_led_n_o               // activity leds, active low
);

   //******************************
   //* spi line switch
   //******************************
   sd_spi_t sel_spi;                              // or of the masked controller lines
   logic    any_grant;                            // card has an owner

   // and-or mux, grant is one-hot so at most one term survives
   always_comb begin
      sel_spi = '0;
      for (int i = 0; i < n_ctrl; i++) begin
         sel_spi = sel_spi | (ctrl_spi_i[i] & {$bits(sd_spi_t){grant_i[i]}});
      end
   end

   assign any_grant = |grant_i;

   // no owner, park the card deselected with the clock low
   assign card_spi_o = any_grant ? sel_spi : idle_spi;

   //******************************
   //* activity leds
   //******************************
   // taken from the raw request so the led lights without sync delay
   assign disk_led_n_o = ~req_i;                  // lit while requesting

endmodule

// File: hdl/sd_grant_arbiter.sv
`timescale 1ns/100ps

// hands the card to one controller at a time
// lowest ctrl_e value wins, a running owner is never preempted
module sd_grant_arbiter
   import sd_dispatch_pkg::*;
(
   input  logic      sdclock,                     // sd card clock
   input  logic      arst_n_i,                    // async reset, active low
   input  ctrl_vec_t req_sync_i,                  // requests already in sdclock domain
   output ctrl_vec_t grant_o                      // one-hot grant or all zero
);

   //******************************
   //* helpers
   //******************************
   // first requester in priority order
   function automatic ctrl_e pick_first(input ctrl_vec_t req);
      ctrl_e sel;
      sel = CTRL_MY;                              // only taken when req is nonzero
      for (int i = n_ctrl - 1; i >= 0; i--) begin
         if (req[i]) begin
            sel = ctrl_e'(i);                     // lower index overrides
         end
      end
      return sel;
   endfunction

   // controller index to grant vector
   function automatic ctrl_vec_t to_onehot(input ctrl_e sel);
      ctrl_vec_t vec;
      vec      = '0;
      vec[sel] = 1'b1;
      return vec;
   endfunction

   //******************************
   //* state
   //******************************
   arb_state_e state_q;                           // free or owned
   arb_state_e state_d;
   ctrl_vec_t  grant_q;                           // registered grant
   ctrl_vec_t  grant_d;
   ctrl_e      owner_q;                           // who holds the card
   ctrl_e      owner_d;

   //******************************
   //* next state
   //******************************
   always_comb begin
      state_d = state_q;                          // hold by default
      grant_d = grant_q;
      owner_d = owner_q;
      case (state_q)
         ARB_IDLE: begin
            if (|req_sync_i) begin
               owner_d = pick_first(req_sync_i);  // fixed priority scan
               grant_d = to_onehot(owner_d);
               state_d = ARB_BUSY;
            end
         end
         ARB_BUSY: begin
            // other requests are ignored, they keep waiting
            if (!req_sync_i[owner_q]) begin
               grant_d = '0;                      // owner let go
               state_d = ARB_IDLE;                // leaves one free cycle
            end
         end
      endcase
   end

   //******************************
   //* registers
   //******************************
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ARB_IDLE;
         grant_q <= '0;                           // card free after reset
         owner_q <= CTRL_RK;
      end else begin
         state_q <= state_d;
         grant_q <= grant_d;
         owner_q <= owner_d;
      end
   end

   assign grant_o = grant_q;                      // straight from the flops

endmodule

// File: hdl/sd_req_sync.sv
`timescale 1ns/100ps

// requests arrive from the bus clock of each controller and are
// brought into the sdclock domain here
module sd_req_sync
   import sd_dispatch_pkg::*;
(
   input  logic      sdclock,                     // sd card clock
   input  logic      arst_n_i,                    // async reset, active low
   input  ctrl_vec_t req_i,                       // raw requests, foreign domain
   output ctrl_vec_t req_sync_o                   // filtered requests
);

   //******************************
   //* shift chains
   //******************************
   // one column per stage, all controllers side by side
   ctrl_vec_t [sync_depth-1:0] stage_q;           // stage 0 samples the raw level

   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stage_q <= '0;                           // no request seen
      end else begin
         stage_q[0] <= req_i;                     // first flop, may go metastable
         for (int i = 1; i < sync_depth; i++) begin
            stage_q[i] <= stage_q[i-1];           // settle through the chain
         end
      end
   end

   // a pulse shorter than one sdclock period is usually lost here
   // which is fine since the handshake holds the level until grant
   assign req_sync_o = stage_q[sync_depth-1];     // last stage only

endmodule

// File: common/sd_dispatch_pkg.sv
package sd_dispatch_pkg;

   //******************************
   //* dispatcher sizes
   //******************************
   localparam int n_ctrl     = 6;                 // disk controllers on one card
   localparam int sync_depth = 2;                 // filter stages per request
   localparam int ctrl_w     = $clog2(n_ctrl);    // width of a controller index

   //******************************
   //* card idle levels
   //******************************
   localparam logic idle_cs   = 1'b1;             // card deselected
   localparam logic idle_mosi = 1'b1;             // data line parked high
   localparam logic idle_sclk = 1'b0;             // clock parked low

   //******************************
   //* controller identity
   //******************************
   // order of the list is the grant priority, RK wins
   typedef enum logic [ctrl_w-1:0] {
      CTRL_RK = 3'd0,                             // RK11 cartridge disk
      CTRL_DW = 3'd1,                             // DW winchester
      CTRL_DM = 3'd2,                             // RK611 disk
      CTRL_DB = 3'd3,                             // RH70 massbus disk
      CTRL_DX = 3'd4,                             // RX01 floppy
      CTRL_MY = 3'd5                              // MY floppy
   } ctrl_e;

   // one bit per controller, bit index is ctrl_e
   typedef logic [n_ctrl-1:0] ctrl_vec_t;

   //******************************
   //* spi lines
   //******************************
   typedef struct packed {
      logic cs;                                   // chip select, active low
      logic mosi;                                 // data toward the card
      logic sclk;                                 // serial clock
   } sd_spi_t;

   // card outputs of all controllers, element index is ctrl_e
   typedef sd_spi_t [n_ctrl-1:0] sd_spi_vec_t;

   // lines driven onto the card with no owner
   localparam sd_spi_t idle_spi = '{
      cs:   idle_cs,
      mosi: idle_mosi,
      sclk: idle_sclk
   };

   //******************************
   //* arbiter states
   //******************************
   typedef enum logic {
      ARB_IDLE = 1'b0,                            // card free, scanning requests
      ARB_BUSY = 1'b1                             // card owned, waiting for release
   } arb_state_e;

endpackage
